// File: verilog.f
+incdir+bench
src/ooo_pkg.sv
src/rat.sv
src/rob.sv
src/rename_ctrl.sv
src/rename_core.sv
bench/rename_core_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = rename_core_tb
FILELIST = verilog.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Verification passed" $(LOG) || (echo "test target: run failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/rename_tasks.svh
// drivers, checks and directed tests; needs the signals and model state of the testbench module
task automatic stop_run();
  $display("Verification failed");
  $fatal(1, "run stopped at the first error");
endtask

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    stop_run();
  end
endtask

// drive a writeback for the current cycle, model follows at once
task automatic drive_wb(input logic [tagw-1:0] id, input word_t res, input logic err);
  wb_valid  <= 1'b1;
  wb_error  <= err;
  wb_robid  <= id;
  wb_rd     <= {~ent_has_rd[id], ent_rd[id]};
  wb_result <= res;
  apply_wb(id, res, err);
endtask

task automatic send_wb(input logic [tagw-1:0] id, input word_t res, input logic err);
  @(posedge clk);
  drive_wb(id, res, err);
  @(posedge clk);
  wb_valid <= 1'b0;
endtask

// one instruction through the input handshake, optionally with a writeback in the same cycle
task automatic rename_op(input reg_idx_t rs1, input reg_idx_t rs2, input reg_idx_t rd,
                         input logic has_rd, input logic with_wb,
                         input logic [tagw-1:0] fwd_id, input word_t fwd_res,
                         output logic [tagw-1:0] id);
  logic  v1;
  logic  v2;
  word_t t1;
  word_t t2;
  int    waited;
  @(posedge clk);
  in_valid  <= 1'b1;
  in_rs1    <= rs1;
  in_rs2    <= rs2;
  in_rd     <= rd;
  in_has_rd <= has_rd;
  if (with_wb) begin
    drive_wb(fwd_id, fwd_res, 1'b0);
  end
  waited = 0;
  @(negedge clk);
  while (!in_ready) begin
    waited++;
    if (waited > wait_limit) begin
      $display("in_ready stayed low for %0d cycles while an instruction waited", wait_limit);
      stop_run();
    end
    @(posedge clk);
    wb_valid <= 1'b0;
    @(negedge clk);
  end
  id = next_robid;
  expect_src(rs1, v1, t1);
  expect_src(rs2, v2, t2);
  @(posedge clk);
  in_valid <= 1'b0;
  wb_valid <= 1'b0;
  record_alloc(id, rd, has_rd);
  @(negedge clk);
  check_val("disp_valid", 32'(disp_valid), 32'd1);
  check_val("disp_robid", 32'(disp_robid), 32'(id));
  check_val("disp_rs1_valid", 32'(disp_rs1_valid), 32'(v1));
  check_val("disp_rs1_tagval", disp_rs1_tagval, t1);
  check_val("disp_rs2_valid", 32'(disp_rs2_valid), 32'(v2));
  check_val("disp_rs2_tagval", disp_rs2_tagval, t2);
endtask

task automatic rename_plain(input reg_idx_t rs1, input reg_idx_t rs2, input reg_idx_t rd,
                            input logic has_rd, output logic [tagw-1:0] id);
  rename_op(rs1, rs2, rd, has_rd, 1'b0, '0, '0, id);
endtask

// reader of rs with no destination, completed right away
task automatic read_reg(input reg_idx_t rs, input word_t exp);
  logic [tagw-1:0] id;
  rename_plain(rs, '0, '0, 1'b0, id);
  check_val("disp_rs1_valid", 32'(disp_rs1_valid), 32'd1);
  check_val("disp_rs1_tagval", disp_rs1_tagval, exp);
  send_wb(id, pick_word(), 1'b0);
endtask

task automatic wait_drain();
  int waited;
  waited = 0;
  while (pend_q.size() != 0) begin
    @(negedge clk);
    waited++;
    if (waited > wait_limit) begin
      $display("%0d instructions never retired", pend_q.size());
      stop_run();
    end
  end
endtask

task automatic note_retire();
  logic [tagw-1:0] id;
  if (pend_q.size() == 0) begin
    $display("ret_valid pulsed with no instruction in flight");
    stop_run();
  end
  id = pend_q.pop_front();
  if (ent_err[id]) begin
    $display("an instruction that reported an error was retired");
    stop_run();
  end
  check_val("ret_robid", 32'(ret_robid), 32'(id));
  check_val("ret_rd", 32'(ret_rd), 32'(ent_rd[id]));
  check_val("ret_result", ret_result, wb_data[id]);
  if (ent_has_rd[id]) begin
    arch_val[ent_rd[id]] = wb_data[id];
  end
endtask

task automatic test_reset_reads();
  logic [tagw-1:0] id;
  reg_idx_t        r;
  for (int i = 0; i < 4; i++) begin
    r = pick_reg();
    rename_plain(r, pick_reg(), r, 1'b0, id);
    check_val("disp_rs1_valid", 32'(disp_rs1_valid), 32'd1);
    check_val("disp_rs1_tagval", disp_rs1_tagval, 32'd0);
    send_wb(id, pick_word(), 1'b0);
  end
  // r0 is never renamed
  rename_plain('0, pick_reg(), '0, 1'b1, id);
  check_val("disp_rs1_tagval", disp_rs1_tagval, 32'd0);
  send_wb(id, pick_word(), 1'b0);
  read_reg('0, '0);
  wait_drain();
endtask

task automatic test_dependency();
  logic [tagw-1:0] w;
  logic [tagw-1:0] id;
  reg_idx_t        a;
  a = pick_reg();
  rename_plain(pick_reg(), pick_reg(), a, 1'b1, w);
  rename_plain(a, '0, '0, 1'b0, id);
  check_val("disp_rs1_valid", 32'(disp_rs1_valid), 32'd0);
  check_val("disp_rs1_tagval", disp_rs1_tagval, 32'(w));
  send_wb(w, pick_word(), 1'b0);
  send_wb(id, pick_word(), 1'b0);
  wait_drain();
endtask

task automatic test_forwarding();
  logic [tagw-1:0] w;
  logic [tagw-1:0] id;
  reg_idx_t        a;
  reg_idx_t        b;
  word_t           va;
  word_t           vb;
  a  = pick_reg();
  b  = next_reg(a);
  va = pick_word();
  vb = pick_word();
  rename_plain(pick_reg(), pick_reg(), a, 1'b1, w);
  send_wb(w, va, 1'b0);
  read_reg(a, va);
  // writeback lands in the accept cycle of the reader
  rename_plain(pick_reg(), pick_reg(), b, 1'b1, w);
  rename_op(b, a, '0, 1'b0, 1'b1, w, vb, id);
  check_val("disp_rs1_valid", 32'(disp_rs1_valid), 32'd1);
  check_val("disp_rs1_tagval", disp_rs1_tagval, vb);
  check_val("disp_rs2_tagval", disp_rs2_tagval, va);
  send_wb(id, pick_word(), 1'b0);
  wait_drain();
endtask

task automatic test_inorder_retire();
  logic [tagw-1:0] ids [4];
  reg_idx_t        a;
  reg_idx_t        b;
  reg_idx_t        c;
  word_t           vals [4];
  a = pick_reg();
  b = next_reg(a);
  c = next_reg(b);
  for (int i = 0; i < 4; i++) begin
    vals[i] = pick_word();
  end
  rename_plain(a, b, a, 1'b1, ids[0]);
  rename_plain(c, a, b, 1'b1, ids[1]);
  rename_plain(b, c, a, 1'b1, ids[2]);
  rename_plain(a, a, c, 1'b1, ids[3]);
  // youngest first; the last one is stale for register a
  for (int i = 3; i >= 0; i--) begin
    send_wb(ids[i], vals[i], 1'b0);
  end
  wait_drain();
  read_reg(a, vals[2]);
  read_reg(b, vals[1]);
  read_reg(c, vals[3]);
  wait_drain();
endtask

task automatic test_error_flush();
  logic [tagw-1:0] ida;
  logic [tagw-1:0] idb;
  logic [tagw-1:0] idc;
  logic [tagw-1:0] id;
  reg_idx_t        a;
  reg_idx_t        b;
  reg_idx_t        c;
  word_t           va;
  word_t           exp_b;
  word_t           exp_c;
  int              waited;
  a     = pick_reg();
  b     = next_reg(a);
  c     = next_reg(b);
  va    = pick_word();
  exp_b = arch_val[b];
  exp_c = arch_val[c];
  rename_plain(pick_reg(), pick_reg(), a, 1'b1, ida);
  rename_plain(pick_reg(), pick_reg(), b, 1'b1, idb);
  rename_plain(pick_reg(), pick_reg(), c, 1'b1, idc);
  send_wb(idc, pick_word(), 1'b0);
  send_wb(idb, pick_word(), 1'b1);
  send_wb(ida, va, 1'b0);
  waited = 0;
  @(negedge clk);
  while (!flush) begin
    waited++;
    if (waited > wait_limit) begin
      $display("no flush after an error writeback reached the ROB head");
      stop_run();
    end
    @(negedge clk);
  end
  check_val("in_ready", 32'(in_ready), 32'd0);
  // error entry and its younger neighbor are still unretired
  check_val("entries left at flush", 32'(pend_q.size()), 32'd2);
  model_flush();
  @(negedge clk);
  check_val("flush", 32'(flush), 32'd0);
  rename_plain(a, b, '0, 1'b0, id);
  check_val("disp_robid", 32'(disp_robid), 32'd0);
  check_val("disp_rs1_tagval", disp_rs1_tagval, va);
  check_val("disp_rs2_tagval", disp_rs2_tagval, exp_b);
  send_wb(id, pick_word(), 1'b0);
  read_reg(c, exp_c);
  wait_drain();
endtask

task automatic test_backpressure();
  logic [tagw-1:0] id;
  logic [tagw-1:0] ids [rob_depth];
  word_t           held1;
  word_t           held2;
  int              waited;
  @(posedge clk);
  disp_ready <= 1'b0;
  rename_plain(pick_reg(), pick_reg(), '0, 1'b0, id);
  held1 = disp_rs1_tagval;
  held2 = disp_rs2_tagval;
  repeat (4) begin
    @(negedge clk);
    check_val("disp_valid", 32'(disp_valid), 32'd1);
    check_val("disp_robid", 32'(disp_robid), 32'(id));
    check_val("disp_rs1_tagval", disp_rs1_tagval, held1);
    check_val("disp_rs2_tagval", disp_rs2_tagval, held2);
    check_val("in_ready", 32'(in_ready), 32'd0);
  end
  @(posedge clk);
  disp_ready <= 1'b1;
  send_wb(id, pick_word(), 1'b0);
  wait_drain();
  // fill the ROB with nothing completing
  for (int i = 0; i < rob_depth; i++) begin
    rename_plain(pick_reg(), pick_reg(), '0, 1'b0, ids[i]);
  end
  repeat (3) begin
    @(negedge clk);
    check_val("in_ready", 32'(in_ready), 32'd0);
  end
  send_wb(ids[0], pick_word(), 1'b0);
  waited = 0;
  @(negedge clk);
  while (!in_ready) begin
    waited++;
    if (waited > wait_limit) begin
      $display("in_ready did not return after the oldest entry retired");
      stop_run();
    end
    @(negedge clk);
  end
  for (int i = 1; i < rob_depth; i++) begin
    send_wb(ids[i], pick_word(), 1'b0);
  end
  wait_drain();
endtask

// File: bench/rename_core_tb.sv
// rob_depth is fixed at 16; expected values come from a small RAT and ROB model kept in the testbench
`timescale 1ns/1ns

module rename_core_tb
  import ooo_pkg::*;
();

  localparam int rob_depth       = 16;
  localparam int tagw            = $clog2(rob_depth);
  localparam int clk_period      = 8;
  localparam int num_tests       = 6;
  localparam int cycles_per_test = 400;
  localparam int watchdog_cycles = num_tests * cycles_per_test;
  localparam int wait_limit      = 64;

  logic            clk;
  logic            rst_n;
  logic            in_valid;
  logic            in_ready;
  reg_idx_t        in_rs1;
  reg_idx_t        in_rs2;
  reg_idx_t        in_rd;
  logic            in_has_rd;
  logic            disp_valid;
  logic            disp_ready;
  logic [tagw-1:0] disp_robid;
  logic            disp_rs1_valid;
  word_t           disp_rs1_tagval;
  logic            disp_rs2_valid;
  word_t           disp_rs2_tagval;
  logic            wb_valid;
  logic            wb_error;
  logic [tagw-1:0] wb_robid;
  wb_rd_t          wb_rd;
  word_t           wb_result;
  logic            ret_valid;
  logic [tagw-1:0] ret_robid;
  reg_idx_t        ret_rd;
  word_t           ret_result;
  logic            flush;

  // model: committed values, readable values and current aliases
  word_t                arch_val [nregs];
  word_t                cur_val [nregs];
  logic [nregs-1:0]     busy;
  logic [tagw-1:0]      alias_tag [nregs];
  logic [tagw-1:0]      next_robid;
  // model: per ROB entry
  reg_idx_t             ent_rd [rob_depth];
  logic [rob_depth-1:0] ent_has_rd;
  logic [rob_depth-1:0] ent_err;
  word_t                wb_data [rob_depth];
  logic [tagw-1:0]      pend_q [$];
  int                   flush_cnt;
  logic [15:0]          lfsr_q;

  rename_core #(.rob_depth(rob_depth)) uut (.*);

  `include "rename_tasks.svh"

  // fibonacci lfsr, taps 16 14 13 11, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  // nonzero register number
  function automatic reg_idx_t pick_reg();
    reg_idx_t r;
    r = reg_idx_t'(rand_bits(regw));
    if (r == '0) begin
      r = reg_idx_t'(1);
    end
    return r;
  endfunction

  function automatic word_t pick_word();
    return rand_bits(xlen);
  endfunction

  function automatic reg_idx_t next_reg(input reg_idx_t r);
    return (r == reg_idx_t'(nregs - 1)) ? reg_idx_t'(1) : r + reg_idx_t'(1);
  endfunction

  function automatic void model_reset();
    for (int r = 0; r < nregs; r++) begin
      arch_val[r]  = '0;
      cur_val[r]   = '0;
      alias_tag[r] = '0;
    end
    for (int e = 0; e < rob_depth; e++) begin
      ent_rd[e]  = '0;
      wb_data[e] = '0;
    end
    busy       = '0;
    ent_has_rd = '0;
    ent_err    = '0;
    next_robid = '0;
    pend_q.delete();
  endfunction

  // after a flush every register reads its committed value
  function automatic void model_flush();
    for (int r = 0; r < nregs; r++) begin
      cur_val[r] = arch_val[r];
    end
    busy       = '0;
    next_robid = '0;
    pend_q.delete();
  endfunction

  function automatic void expect_src(input reg_idx_t rs, output logic v, output word_t tv);
    if (rs == '0) begin
      v  = 1'b1;
      tv = '0;
    end else if (busy[rs]) begin
      v  = 1'b0;
      tv = word_t'(alias_tag[rs]);
    end else begin
      v  = 1'b1;
      tv = cur_val[rs];
    end
  endfunction

  // only the newest alias of a register takes a good result
  function automatic void apply_wb(input logic [tagw-1:0] id, input word_t res, input logic err);
    reg_idx_t r;
    r           = ent_rd[id];
    wb_data[id] = res;
    ent_err[id] = err;
    if (!err && ent_has_rd[id] && r != '0 && busy[r] && alias_tag[r] == id) begin
      cur_val[r] = res;
      busy[r]    = 1'b0;
    end
  endfunction

  function automatic void record_alloc(input logic [tagw-1:0] id, input reg_idx_t rd,
                                       input logic has_rd);
    ent_rd[id]     = rd;
    ent_has_rd[id] = has_rd;
    ent_err[id]    = 1'b0;
    wb_data[id]    = '0;
    pend_q.push_back(id);
    if (has_rd && rd != '0) begin
      busy[rd]      = 1'b1;
      alias_tag[rd] = id;
    end
    next_robid = next_robid + tagw'(1);
  endfunction

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles before the tests finished", watchdog_cycles);
    stop_run();
  end

  // retirement and flush monitor
  always @(negedge clk) begin
    if (rst_n) begin
      if (flush) begin
        flush_cnt++;
      end
      if (ret_valid) begin
        note_retire();
      end
    end
  end

  initial begin
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_rs1     = '0;
    in_rs2     = '0;
    in_rd      = '0;
    in_has_rd  = 1'b0;
    disp_ready = 1'b1;
    wb_valid   = 1'b0;
    wb_error   = 1'b0;
    wb_robid   = '0;
    wb_rd      = '0;
    wb_result  = '0;
    lfsr_q     = 16'd23;
    flush_cnt  = 0;
    model_reset();
    repeat (7) @(posedge clk);
    // outputs while reset is still held
    @(negedge clk);
    check_val("in_ready", 32'(in_ready), 32'd0);
    check_val("disp_valid", 32'(disp_valid), 32'd0);
    check_val("ret_valid", 32'(ret_valid), 32'd0);
    check_val("flush", 32'(flush), 32'd0);
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_val("disp_valid", 32'(disp_valid), 32'd0);
    check_val("ret_valid", 32'(ret_valid), 32'd0);
    check_val("flush", 32'(flush), 32'd0);
    test_reset_reads();
    test_dependency();
    test_forwarding();
    test_inorder_retire();
    test_error_flush();
    test_backpressure();
    check_val("flush count", 32'(flush_cnt), 32'd1);
    $display("Verification passed");
    $finish;
  end

endmodule

// File: src/rename_core.sv
// rob_depth must be a power of two of at least 2; writebacks are single-cycle pulses without ready
`timescale 1ns/1ns

module rename_core
  import ooo_pkg::*;
#(
  parameter int rob_depth = 16,
  localparam int tagw = $clog2(rob_depth)
) (
  input  logic            clk,
  input  logic            rst_n,

  // instruction input
  input  logic            in_valid,
  output logic            in_ready,
  input  reg_idx_t        in_rs1,
  input  reg_idx_t        in_rs2,
  input  reg_idx_t        in_rd,
  input  logic            in_has_rd,

  // dispatch output
  output logic            disp_valid,
  input  logic            disp_ready,
  output logic [tagw-1:0] disp_robid,
  output logic            disp_rs1_valid,
  output word_t           disp_rs1_tagval,
  output logic            disp_rs2_valid,
  output word_t           disp_rs2_tagval,

  // writeback from execution
  input  logic            wb_valid,
  input  logic            wb_error,
  input  logic [tagw-1:0] wb_robid,
  input  wb_rd_t          wb_rd,
  input  word_t           wb_result,

  // retirement
  output logic            ret_valid,
  output logic [tagw-1:0] ret_robid,
  output reg_idx_t        ret_rd,
  output word_t           ret_result,
  output logic            flush
);

  // rename lookup
  logic            rename_alloc;
  reg_idx_t        rename_rs1;
  reg_idx_t        rename_rs2;
  reg_idx_t        rename_rd;
  logic [tagw-1:0] rename_robid;
  logic            rat_rs1_valid;
  word_t           rat_rs1_tagval;
  logic            rat_rs2_valid;
  word_t           rat_rs2_tagval;

  // ROB allocation and head
  logic            alloc;
  reg_idx_t        alloc_rd;
  logic            alloc_has_rd;
  logic [tagw-1:0] tail_robid;
  logic            full;
  logic            retire;
  logic            head_valid;
  reg_idx_t        head_rd;
  logic            head_has_rd;
  logic            head_error;
  word_t           head_result;

  // commit into the RAT
  logic            rob_ret_commit;
  reg_idx_t        rob_ret_rd;
  word_t           rob_ret_result;

  rename_ctrl #(.rob_depth(rob_depth)) u_ctrl (.*);

  rat #(.rob_depth(rob_depth)) u_rat (
    .rob_flush (flush),
    .*
  );

  rob #(.rob_depth(rob_depth)) u_rob (.*);

endmodule

// File: src/rename_ctrl.sv
// one accept and one retire per cycle; an error at the ROB head blocks intake until the flush pulse
`timescale 1ns/1ns

module rename_ctrl
  import ooo_pkg::*;
#(
  parameter int rob_depth = 16,
  localparam int tagw = $clog2(rob_depth)
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            in_valid,
  output logic            in_ready,
  input  reg_idx_t        in_rs1,
  input  reg_idx_t        in_rs2,
  input  reg_idx_t        in_rd,
  input  logic            in_has_rd,
  output logic            rename_alloc,
  output reg_idx_t        rename_rs1,
  output reg_idx_t        rename_rs2,
  output reg_idx_t        rename_rd,
  output logic [tagw-1:0] rename_robid,
  input  logic            rat_rs1_valid,
  input  word_t           rat_rs1_tagval,
  input  logic            rat_rs2_valid,
  input  word_t           rat_rs2_tagval,
  output logic            alloc,
  output reg_idx_t        alloc_rd,
  output logic            alloc_has_rd,
  input  logic            full,
  input  logic [tagw-1:0] tail_robid,
  output logic            disp_valid,
  input  logic            disp_ready,
  output logic [tagw-1:0] disp_robid,
  output logic            disp_rs1_valid,
  output word_t           disp_rs1_tagval,
  output logic            disp_rs2_valid,
  output word_t           disp_rs2_tagval,
  input  logic            head_valid,
  input  reg_idx_t        head_rd,
  input  logic            head_has_rd,
  input  logic            head_error,
  input  word_t           head_result,
  output logic            retire,
  output logic            rob_ret_commit,
  output reg_idx_t        rob_ret_rd,
  output word_t           rob_ret_result,
  output logic            ret_valid,
  output logic [tagw-1:0] ret_robid,
  output reg_idx_t        ret_rd,
  output word_t           ret_result,
  output logic            flush
);

  logic            accept;
  logic            err_at_head;
  logic [tagw-1:0] head_robid;

  // error waiting at the head counts as a flush in progress
  assign err_at_head = head_valid && head_error;
  // no intake while in reset
  assign in_ready    = rst_n && !full && !flush && !err_at_head &&
                       (!disp_valid || disp_ready);
  assign accept      = in_valid && in_ready;

  assign rename_rs1   = in_rs1;
  assign rename_rs2   = in_rs2;
  assign rename_rd    = in_rd;
  assign rename_robid = tail_robid;
  // r0 never gets an alias
  assign rename_alloc = accept && in_has_rd && (in_rd != '0);

  assign alloc        = accept;
  assign alloc_rd     = in_rd;
  assign alloc_has_rd = in_has_rd;

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      disp_valid <= 1'b0;
    end else if (accept) begin
      disp_valid <= 1'b1;
    end else if (disp_ready) begin
      disp_valid <= 1'b0;
    end
  end

  // operands sampled with forwarding at the accepting edge
  always_ff @(posedge clk) begin
    if (accept) begin
      disp_robid      <= tail_robid;
      disp_rs1_valid  <= rat_rs1_valid;
      disp_rs1_tagval <= rat_rs1_tagval;
      disp_rs2_valid  <= rat_rs2_valid;
      disp_rs2_tagval <= rat_rs2_tagval;
    end
  end

  // good entries pop; error entry stays until the flush clears the ROB
  assign retire         = head_valid && !head_error && !flush;
  assign rob_ret_commit = retire && head_has_rd;
  assign rob_ret_rd     = head_rd;
  assign rob_ret_result = head_result;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flush      <= 1'b0;
      ret_valid  <= 1'b0;
      head_robid <= '0;
    end else begin
      flush     <= err_at_head && !flush;
      ret_valid <= retire;
      if (flush) begin
        head_robid <= '0;
      end else if (retire) begin
        head_robid <= head_robid + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (retire) begin
      ret_robid  <= head_robid;
      ret_rd     <= head_rd;
      ret_result <= head_result;
    end
  end

endmodule

// File: src/rob.sv
// rob_depth must be a power of two of at least 2; writebacks are expected only for live entries
`timescale 1ns/1ns

module rob
  import ooo_pkg::*;
#(
  parameter int rob_depth = 16,
  localparam int tagw = $clog2(rob_depth)
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            flush,

  // allocation at the tail
  input  logic            alloc,
  input  reg_idx_t        alloc_rd,
  input  logic            alloc_has_rd,
  output logic [tagw-1:0] tail_robid,
  output logic            full,

  // completion
  input  logic            wb_valid,
  input  logic            wb_error,
  input  logic [tagw-1:0] wb_robid,
  input  word_t           wb_result,

  // head entry
  input  logic            retire,
  output logic            head_valid,
  output reg_idx_t        head_rd,
  output logic            head_has_rd,
  output logic            head_error,
  output word_t           head_result
);

  logic [tagw-1:0] head_q;
  logic [tagw-1:0] tail_q;
  logic [tagw:0]   count_q;
  logic [rob_depth-1:0] done_q;

  // entry payload
  reg_idx_t             rd_q [rob_depth];
  logic [rob_depth-1:0] has_rd_q;
  logic [rob_depth-1:0] error_q;
  word_t                result_q [rob_depth];

  assign tail_robid = tail_q;
  assign full       = (count_q == (tagw + 1)'(rob_depth));

  // head may leave once its result is in
  assign head_valid  = (count_q != '0) && done_q[head_q];
  assign head_rd     = rd_q[head_q];
  assign head_has_rd = has_rd_q[head_q];
  assign head_error  = error_q[head_q];
  assign head_result = result_q[head_q];

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (alloc) begin
        tail_q <= tail_q + 1'b1;
      end
      if (retire) begin
        head_q <= head_q + 1'b1;
      end
      case ({alloc, retire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // a fresh entry starts not done; a flushed slot is cleared when reused
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done_q <= '0;
    end else begin
      if (alloc) begin
        done_q[tail_q] <= 1'b0;
      end
      if (wb_valid) begin
        done_q[wb_robid] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alloc) begin
      rd_q[tail_q]     <= alloc_rd;
      has_rd_q[tail_q] <= alloc_has_rd;
    end
    // stale results are still recorded, the entry must complete
    if (wb_valid) begin
      result_q[wb_robid] <= wb_result;
      error_q[wb_robid]  <= wb_error;
    end
  end

endmodule

// File: src/rat.sv
// rob_depth must be a power of two; a late writeback from a flushed instruction must not hit a live tag
`timescale 1ns/1ns

module rat
  import ooo_pkg::*;
#(
  parameter int rob_depth = 16,
  localparam int tagw = $clog2(rob_depth)
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            rob_flush,

  // rename lookup and allocation
  input  reg_idx_t        rename_rs1,
  input  reg_idx_t        rename_rs2,
  input  logic            rename_alloc,
  input  reg_idx_t        rename_rd,
  input  logic [tagw-1:0] rename_robid,
  output logic            rat_rs1_valid,
  output word_t           rat_rs1_tagval,
  output logic            rat_rs2_valid,
  output word_t           rat_rs2_tagval,

  // writeback
  input  logic            wb_valid,
  input  logic            wb_error,
  input  logic [tagw-1:0] wb_robid,
  input  wb_rd_t          wb_rd,
  input  word_t           wb_result,

  // retire commit
  input  logic            rob_ret_commit,
  input  reg_idx_t        rob_ret_rd,
  input  word_t           rob_ret_result
);

  // per register state
  logic [nregs-1:0] valid_q;
  logic [nregs-1:0] committed_q;
  logic [tagw-1:0]  tag_q [nregs];
  word_t            spec_q [nregs];
  word_t            comm_q [nregs];

  reg_idx_t wb_idx;
  logic     wb_write;
  logic     alloc_conflict;

  assign wb_idx = wb_rd[regw-1:0];

  // only the newest alias still in flight takes the value
  assign wb_write = wb_valid && !wb_error && !wb_rd[regw] && !valid_q[wb_idx] &&
                    (tag_q[wb_idx] == wb_robid);

  // new alias for the same register in this cycle beats the writeback
  assign alloc_conflict = rename_alloc && (rename_rd == wb_idx);

  always_ff @(posedge clk) begin
    if (!rst_n || rob_flush) begin
      valid_q     <= '1;
      committed_q <= '1;
    end else begin
      if (wb_write && !alloc_conflict) begin
        valid_q[wb_idx] <= 1'b1;
      end
      if (rename_alloc) begin
        valid_q[rename_rd]     <= 1'b0;
        committed_q[rename_rd] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rename_alloc) begin
      tag_q[rename_rd] <= rename_robid;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_write) begin
      spec_q[wb_idx] <= wb_result;
    end
  end

  // committed copy starts at zero and follows retirement
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < nregs; i++) begin
        comm_q[i] <= '0;
      end
    end else if (rob_ret_commit) begin
      comm_q[rob_ret_rd] <= rob_ret_result;
    end
  end

  function automatic logic fwd_hit(input reg_idx_t rs);
    return wb_write && (wb_idx == rs);
  endfunction

  function automatic logic src_valid(input reg_idx_t rs);
    return (rs == '0) || fwd_hit(rs) || valid_q[rs];
  endfunction

  // priority: r0, forwarded result, committed, speculative, then producer tag
  function automatic word_t src_tagval(input reg_idx_t rs);
    word_t tv;
    if (rs == '0) begin
      tv = '0;
    end else if (fwd_hit(rs)) begin
      tv = wb_result;
    end else if (committed_q[rs]) begin
      tv = comm_q[rs];
    end else if (valid_q[rs]) begin
      tv = spec_q[rs];
    end else begin
      tv = word_t'(tag_q[rs]);
    end
    return tv;
  endfunction

  always_comb begin
    rat_rs1_valid  = src_valid(rename_rs1);
    rat_rs1_tagval = src_tagval(rename_rs1);
    rat_rs2_valid  = src_valid(rename_rs2);
    rat_rs2_tagval = src_tagval(rename_rs2);
  end

endmodule

// File: src/ooo_pkg.sv
// fixed to a 32-bit word and a 32-entry register file; ROB size is a module parameter, not here
package ooo_pkg;

  // data word width
  parameter int xlen = 32;

  // architectural integer registers
  parameter int nregs = 32;

  // bits needed to index a register
  parameter int regw = $clog2(nregs);

  // architectural register index
  typedef logic [regw-1:0] reg_idx_t;

  // writeback destination; msb set means the instruction writes no register
  typedef logic [regw:0] wb_rd_t;

  // data word, also carries a zero-extended ROB tag
  typedef logic [xlen-1:0] word_t;

endpackage
